//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := dcache_tb
FILELIST  := compile.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_word_align.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_sva.sv
dv/dcache_tb.sv

//--- dv/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model #(
  parameter int          LINE_WORDS = 4,
  parameter logic [31:0] SEED       = 32'd96
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_valid_i,
  input  dcache_pkg::mem_wr_t wr_i,
  output logic                wr_ready_o,
  input  logic                rd_req_valid_i,
  input  dcache_pkg::addr_t   rd_addr_i,
  output logic                rd_req_ready_o,
  output logic                rd_valid_o,
  output dcache_pkg::word_t   rd_data_o,
  output logic                rd_last_o
);
  import dcache_pkg::*;

  word_t       mem [addr_t];
  logic [31:0] rng;
  logic [1:0]  wr_wait;
  logic [1:0]  rq_wait;
  logic [1:0]  gap;
  int          wr_beat;
  int          rd_beat;
  logic        rd_active;
  addr_t       rd_base;

  // untouched words read as a mix of every address bit
  function automatic word_t mem_pattern(addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t read_word(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return mem_pattern(a);
  endfunction

  always @(posedge clk or negedge rst_n) begin
    logic [31:0] r;
    if (!rst_n) begin
      rng            = SEED;
      wr_ready_o     <= 1'b0;
      rd_req_ready_o <= 1'b0;
      rd_valid_o     <= 1'b0;
      rd_data_o      <= '0;
      rd_last_o      <= 1'b0;
      wr_wait        <= 2'd1;
      rq_wait        <= 2'd2;
      gap            <= 2'd0;
      wr_beat        <= 0;
      rd_beat        <= 0;
      rd_active      <= 1'b0;
      rd_base        <= '0;
    end else begin
      r = next_rand();
      // write-back beats, ready drops for 0 to 3 cycles after each one
      if (wr_valid_i && wr_ready_o) begin
        mem[wr_i.addr + addr_t'(4 * wr_beat)] = wr_i.data;
        wr_beat    <= wr_i.last ? 0 : wr_beat + 1;
        wr_ready_o <= 1'b0;
        wr_wait    <= r[1:0];
      end else if (!wr_ready_o) begin
        if (wr_wait == 2'd0) begin
          wr_ready_o <= 1'b1;
        end else begin
          wr_wait <= wr_wait - 2'd1;
        end
      end
      if (rd_req_valid_i && rd_req_ready_o) begin
        rd_active      <= 1'b1;
        rd_base        <= rd_addr_i;
        rd_beat        <= 0;
        gap            <= r[3:2];
        rd_req_ready_o <= 1'b0;
        rq_wait        <= r[5:4];
      end else if (!rd_req_ready_o) begin
        if (rq_wait == 2'd0) begin
          rd_req_ready_o <= 1'b1;
        end else begin
          rq_wait <= rq_wait - 2'd1;
        end
      end
      // read beats with random gaps
      rd_valid_o <= 1'b0;
      rd_last_o  <= 1'b0;
      if (rd_active) begin
        if (gap == 2'd0) begin
          rd_valid_o <= 1'b1;
          rd_data_o  <= read_word(rd_base + addr_t'(4 * rd_beat));
          rd_last_o  <= (rd_beat == LINE_WORDS - 1);
          rd_active  <= (rd_beat != LINE_WORDS - 1);
          rd_beat    <= rd_beat + 1;
          gap        <= r[7:6];
        end else begin
          gap <= gap - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
  input wire logic                clk,
  input wire logic                rst_n,
  input wire logic                req_valid_i,
  input wire logic                req_ready_o,
  input wire logic                rsp_valid_o,
  input wire logic                mem_wr_valid_o,
  input wire dcache_pkg::mem_wr_t mem_wr_o,
  input wire logic                mem_wr_ready_i,
  input wire logic                mem_rd_req_valid_o
);
  logic outstanding;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      outstanding <= 1'b1;
    end else if (rsp_valid_o) begin
      outstanding <= 1'b0;
    end
  end

  a_rsp_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> outstanding)
    else $error("response without an accepted request");

  a_wr_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_wr_valid_o && !mem_wr_ready_i) |=> $stable(mem_wr_o))
    else $error("write-back beat changed while stalled");

  a_quiet_during_mem: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_wr_valid_o || mem_rd_req_valid_o) |-> !(req_ready_o || rsp_valid_o))
    else $error("cpu port active during a memory request");

endmodule

bind dcache_top dcache_sva u_sva (
  .clk                (clk),
  .rst_n              (rst_n),
  .req_valid_i        (req_valid_i),
  .req_ready_o        (req_ready_o),
  .rsp_valid_o        (rsp_valid_o),
  .mem_wr_valid_o     (mem_wr_valid_o),
  .mem_wr_o           (mem_wr_o),
  .mem_wr_ready_i     (mem_wr_ready_i),
  .mem_rd_req_valid_o (mem_rd_req_valid_o)
);

`default_nettype wire

//--- dv/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam int LINE_WORDS = DEF_LINE_WORDS;
  localparam int NUM_RAND   = 400;
  localparam int NUM_OPS    = NUM_RAND + 200;
  // two bursts with worst gaps plus both request delays
  localparam int MISS_LEN   = 2 * LINE_WORDS * 4 + 8;
  localparam int MAX_CYCLES = 2 * NUM_OPS * MISS_LEN;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  cpu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  word_t    rsp_rdata;
  logic     mem_wr_valid;
  mem_wr_t  mem_wr;
  logic     mem_wr_ready;
  logic     rd_req_valid;
  addr_t    rd_addr;
  logic     rd_req_ready;
  logic     rd_valid;
  word_t    rd_data;
  logic     rd_last;

  logic [7:0]  model_mem [1024];
  logic [31:0] rng;
  int          cycles;
  int          rd_reqs;
  int          wb_beats;
  int          wb_idx;
  addr_t       last_rd_addr;
  addr_t       wb_base;
  size_e       sizes [5];

  dcache_top UUT (
    .clk (clk), .rst_n (rst_n),
    .req_valid_i (req_valid), .req_i (req), .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid), .rsp_rdata_o (rsp_rdata),
    .mem_wr_valid_o (mem_wr_valid), .mem_wr_o (mem_wr), .mem_wr_ready_i (mem_wr_ready),
    .mem_rd_req_valid_o (rd_req_valid), .mem_rd_addr_o (rd_addr),
    .mem_rd_req_ready_i (rd_req_ready),
    .mem_rd_valid_i (rd_valid), .mem_rd_data_i (rd_data), .mem_rd_last_i (rd_last)
  );

  dcache_mem_model #(.LINE_WORDS (LINE_WORDS), .SEED (32'd96)) u_mem (
    .clk (clk), .rst_n (rst_n),
    .wr_valid_i (mem_wr_valid), .wr_i (mem_wr), .wr_ready_o (mem_wr_ready),
    .rd_req_valid_i (rd_req_valid), .rd_addr_i (rd_addr), .rd_req_ready_o (rd_req_ready),
    .rd_valid_o (rd_valid), .rd_data_o (rd_data), .rd_last_o (rd_last)
  );

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic word_t mem_pattern(addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t model_word(addr_t a);
    int i;
    i = int'(a[9:0]) & ~3;
    return {model_mem[i+3], model_mem[i+2], model_mem[i+1], model_mem[i]};
  endfunction

  function automatic word_t expect_load(size_e sz, addr_t a);
    int          i;
    logic [7:0]  b;
    logic [15:0] h;
    i = int'(a[9:0]);
    b = model_mem[i];
    h = {model_mem[(i+1) % 1024], model_mem[i]};
    case (sz)
      SZ_B:    return {{24{b[7]}}, b};
      SZ_BU:   return {24'h0, b};
      SZ_H:    return {{16{h[15]}}, h};
      SZ_HU:   return {16'h0, h};
      default: return model_word(a);
    endcase
  endfunction

  task automatic apply_store(size_e sz, addr_t a, word_t d);
    int i;
    int n;
    i = int'(a[9:0]);
    n = (sz == SZ_W) ? 4 : ((sz == SZ_H || sz == SZ_HU) ? 2 : 1);
    for (int k = 0; k < n; k++) begin
      model_mem[i+k] = d[8*k +: 8];
    end
  endtask

  // ==========================================================================
  // checks
  // ==========================================================================

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_rdata(word_t got, word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t rsp_rdata_o got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_wr_beat(mem_wr_t got, mem_wr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t mem_wr_o got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // one request waits for acceptance and for its response
  task automatic do_op(op_e op, size_e sz, addr_t a, word_t d, output int lat);
    word_t exp;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op: op, size: sz, addr: a, wdata: d};
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!rsp_valid);
    exp = (op == OP_LOAD) ? expect_load(sz, a) : '0;
    check_rdata(rsp_rdata, exp);
    if (op == OP_STORE) begin
      apply_store(sz, a, d);
    end
  endtask

  function automatic addr_t align_addr(size_e sz, addr_t a);
    if (sz == SZ_W) begin
      return a & ~addr_t'(3);
    end else if (sz == SZ_H || sz == SZ_HU) begin
      return a & ~addr_t'(1);
    end
    return a;
  endfunction

  // ==========================================================================
  // monitors, clock and timeout
  // ==========================================================================

  always @(negedge clk) begin
    if (rst_n && rd_req_valid && rd_req_ready) begin
      rd_reqs++;
      last_rd_addr = rd_addr;
    end
  end

  always @(negedge clk) begin
    mem_wr_t exp;
    if (rst_n && mem_wr_valid && mem_wr_ready) begin
      if (wb_idx == 0) begin
        wb_base = mem_wr.addr;
        // line base inside the 1 KiB window
        check_addr("mem_wr_o.addr", wb_base & ~addr_t'(1024 - 4 * LINE_WORDS), '0);
      end
      exp.addr = wb_base;
      exp.data = model_word(wb_base + addr_t'(4 * wb_idx));
      exp.last = (wb_idx == LINE_WORDS - 1);
      check_wr_beat(mem_wr, exp);
      wb_idx = exp.last ? 0 : wb_idx + 1;
      wb_beats++;
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run("timeout, the cache stopped answering requests");
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin
    int          lat;
    int          count;
    logic [31:0] r;
    size_e       sz;
    addr_t       a;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rng       = 32'd96;
    cycles    = 0;
    rd_reqs   = 0;
    wb_beats  = 0;
    wb_idx    = 0;
    sizes     = '{SZ_B, SZ_H, SZ_W, SZ_BU, SZ_HU};
    for (int i = 0; i < 1024; i += 4) begin
      {model_mem[i+3], model_mem[i+2], model_mem[i+1], model_mem[i]} = mem_pattern(i);
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (!req_ready || rsp_valid || mem_wr_valid || rd_req_valid) begin
      fail_run("control outputs are not idle after reset");
    end

    // first load misses and fetches the line
    do_op(OP_LOAD, SZ_H, 32'h106, '0, lat);
    if (rd_reqs != 1) begin
      fail_run("first load did not issue exactly one read request");
    end
    check_addr("mem_rd_addr_o", last_rd_addr, 32'h100);

    // every store size against every load size on one word
    for (int s = 0; s < 5; s++) begin
      for (int o = 0; o < 4; o++) begin
        if (align_addr(sizes[s], 32'h208 + o) == 32'h208 + o) begin
          do_op(OP_STORE, sizes[s], 32'h208 + o, next_rand(), lat);
          for (int l = 0; l < 5; l++) begin
            for (int p = 0; p < 4; p++) begin
              if (align_addr(sizes[l], 32'h208 + p) == 32'h208 + p) begin
                do_op(OP_LOAD, sizes[l], 32'h208 + p, '0, lat);
              end
            end
          end
        end
      end
    end

    count = rd_reqs;
    do_op(OP_LOAD, SZ_W, 32'h208, '0, lat);
    if (rd_reqs != count || lat != 1) begin
      fail_run("repeated load was not a one cycle hit");
    end

    // A and B fill set 5 and reading A leaves B as the victim for C
    do_op(OP_STORE, SZ_W, 32'h054, 32'h1111_2222, lat);
    do_op(OP_STORE, SZ_W, 32'h158, 32'h3333_4444, lat);
    do_op(OP_LOAD, SZ_W, 32'h054, '0, lat);
    count = wb_beats;
    do_op(OP_LOAD, SZ_W, 32'h250, '0, lat);
    if (wb_beats != count + LINE_WORDS) begin
      fail_run("access to C did not write back a full line");
    end
    check_addr("mem_wr_o.addr", wb_base, 32'h150);
    count = rd_reqs;
    do_op(OP_LOAD, SZ_W, 32'h050, '0, lat);
    if (rd_reqs != count) begin
      fail_run("line A was evicted instead of line B");
    end

    for (int n = 0; n < NUM_RAND; n++) begin
      r  = next_rand();
      sz = sizes[r[3:1] % 5];
      a  = align_addr(sz, {22'h0, r[13:4]});
      do_op(r[0] ? OP_STORE : OP_LOAD, sz, a, next_rand(), lat);
    end

    if (wb_idx != 0) begin
      fail_run("a write-back burst ended without its last beat");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
  parameter int IDX_W      = 4,
  parameter int LINE_WORDS = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // cpu side
  input  logic                               req_valid_i,
  input  dcache_pkg::cpu_req_t               req_i,
  output logic                               req_ready_o,
  output logic                               rsp_valid_o,
  output dcache_pkg::word_t                  rsp_rdata_o,
  // memory side
  output logic                               mem_wr_valid_o,
  output dcache_pkg::mem_wr_t                mem_wr_o,
  input  logic                               mem_wr_ready_i,
  output logic                               mem_rd_req_valid_o,
  output dcache_pkg::addr_t                  mem_rd_addr_o,
  input  logic                               mem_rd_req_ready_i,
  input  logic                               mem_rd_valid_i,
  input  dcache_pkg::word_t                  mem_rd_data_i,
  input  logic                               mem_rd_last_i,
  // tag store
  output logic                               rd_en_o,
  output dcache_pkg::addr_t                  rd_addr_o,
  output dcache_pkg::addr_t                  cmp_addr_o,
  input  logic                               hit_i,
  input  logic                               hit_way_i,
  input  logic                               victim_way_i,
  input  dcache_pkg::meta_t                  victim_meta_i,
  input  dcache_pkg::addr_t                  victim_addr_i,
  output logic                               fill_o,
  output logic                               fill_way_o,
  output logic                               dirty_set_o,
  // data store
  output logic                               line_we_o,
  output dcache_pkg::word_t [LINE_WORDS-1:0] refill_line_o,
  output logic                               word_we_o,
  output logic                               way_o,
  input  dcache_pkg::word_t [LINE_WORDS-1:0] line_i,
  // word align
  output dcache_pkg::size_e                  size_o,
  output logic [1:0]                         ofs_o,
  output dcache_pkg::word_t                  wdata_o,
  input  dcache_pkg::word_t                  rdata_i
);
  import dcache_pkg::*;

  localparam int CNT_W = $clog2(LINE_WORDS);
  localparam int OFS_W = 2 + CNT_W;

  // index and line size are shared with both stores
  if (IDX_W < 1 || IDX_W > 8 || LINE_WORDS < 2 ||
      (LINE_WORDS & (LINE_WORDS - 1)) != 0) begin : g_geom_check
    $error("dcache_ctrl: unsupported cache geometry");
  end

  dc_state_e state_q;
  dc_state_e state_d;
  cpu_req_t  req_q;

  logic [CNT_W-1:0]      wb_cnt_q;
  logic [CNT_W-1:0]      rf_cnt_q;
  word_t [LINE_WORDS-1:0] rf_buf_q;

  logic req_fire;
  logic lookup_hit;
  logic wb_last;
  logic wb_fire;
  logic rf_beat;
  logic rf_done;

  assign req_fire   = req_valid_i && req_ready_o;
  assign lookup_hit = (state_q == ST_LOOKUP) && hit_i;
  assign wb_last    = (wb_cnt_q == CNT_W'(LINE_WORDS - 1));
  assign wb_fire    = mem_wr_valid_o && mem_wr_ready_i;
  assign rf_beat    = (state_q == ST_REFILL) && mem_rd_valid_i;
  assign rf_done    = rf_beat && mem_rd_last_i;

  // ========================================================================
  // miss state machine
  // ========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit_i) begin
          state_d = ST_IDLE;
        end else if (victim_meta_i.valid && victim_meta_i.dirty) begin
          state_d = ST_WB;
        end else begin
          state_d = ST_RD_REQ;
        end
      end
      ST_WB: begin
        if (wb_fire && wb_last) begin
          state_d = ST_RD_REQ;
        end
      end
      ST_RD_REQ: begin
        if (mem_rd_req_ready_i) begin
          state_d = ST_REFILL;
        end
      end
      ST_REFILL: begin
        if (rf_done) begin
          state_d = ST_REPLAY;
        end
      end
      // arrays are re-read here, lookup then sees a hit
      ST_REPLAY: state_d = ST_LOOKUP;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ST_IDLE;
      wb_cnt_q <= '0;
      rf_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // counters wrap back to zero after a full burst
      if (wb_fire) begin
        wb_cnt_q <= wb_cnt_q + 1'b1;
      end
      if (rf_beat) begin
        rf_cnt_q <= rf_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req_i;
    end
    if (rf_beat) begin
      rf_buf_q[rf_cnt_q] <= mem_rd_data_i;
    end
  end

  // ========================================================================
  // array, response and memory port drive
  // ========================================================================

  assign req_ready_o = (state_q == ST_IDLE);
  assign rd_en_o     = req_fire || (state_q == ST_REPLAY);
  assign rd_addr_o   = (state_q == ST_IDLE) ? req_i.addr : req_q.addr;
  assign cmp_addr_o  = req_q.addr;

  assign rsp_valid_o = lookup_hit;
  assign rsp_rdata_o = (req_q.op == OP_LOAD) ? rdata_i : '0;

  assign word_we_o   = lookup_hit && (req_q.op == OP_STORE);
  assign dirty_set_o = word_we_o;
  assign way_o       = (state_q == ST_LOOKUP) ? hit_way_i : victim_way_i;

  // last beat goes straight into the line, it is not buffered yet
  always_comb begin
    refill_line_o           = rf_buf_q;
    refill_line_o[rf_cnt_q] = mem_rd_data_i;
  end

  assign line_we_o  = rf_done;
  assign fill_o     = rf_done;
  assign fill_way_o = victim_way_i;

  assign mem_wr_valid_o = (state_q == ST_WB);
  assign mem_wr_o       = '{addr: victim_addr_i, data: line_i[wb_cnt_q], last: wb_last};

  assign mem_rd_req_valid_o = (state_q == ST_RD_REQ);
  assign mem_rd_addr_o      = {req_q.addr[31:OFS_W], {OFS_W{1'b0}}};

  assign size_o  = req_q.size;
  assign ofs_o   = req_q.addr[1:0];
  assign wdata_o = req_q.wdata;

endmodule

`default_nettype wire

//--- logic/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store #(
  parameter int IDX_W      = 4,
  parameter int LINE_WORDS = 4
) (
  input  logic                               clk,
  input  logic                               rd_en_i,
  input  dcache_pkg::addr_t                  rd_addr_i,
  input  logic                               way_i,
  input  logic                               line_we_i,
  input  dcache_pkg::word_t [LINE_WORDS-1:0] line_i,
  input  logic                               word_we_i,
  input  dcache_pkg::addr_t                  word_addr_i,
  input  dcache_pkg::word_t                  word_i,
  input  dcache_pkg::be_t                    be_i,
  output dcache_pkg::word_t                  word_o,
  output dcache_pkg::word_t [LINE_WORDS-1:0] line_o
);
  import dcache_pkg::*;

  localparam int WRD_W = $clog2(LINE_WORDS);
  localparam int OFS_W = 2 + WRD_W;
  localparam int SETS  = 1 << IDX_W;

  typedef logic [IDX_W-1:0]        idx_t;
  typedef logic [WRD_W-1:0]        wsel_t;
  typedef word_t [LINE_WORDS-1:0] line_t;

  line_t line_mem [2][SETS];
  line_t line_q   [2];

  idx_t  rd_idx;
  idx_t  wr_idx;
  wsel_t wsel;

  assign rd_idx = rd_addr_i[OFS_W +: IDX_W];
  assign wr_idx = word_addr_i[OFS_W +: IDX_W];
  assign wsel   = word_addr_i[2 +: WRD_W];

  // both ways are read; way_i picks one afterwards
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      line_q[0] <= line_mem[0][rd_idx];
      line_q[1] <= line_mem[1][rd_idx];
    end
    if (line_we_i) begin
      line_mem[way_i][wr_idx] <= line_i;
    end else if (word_we_i) begin
      // store hit, merge only the enabled bytes
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          line_mem[way_i][wr_idx][wsel][8*b +: 8] <= word_i[8*b +: 8];
        end
      end
    end
  end

  // full line feeds write-back, the word feeds the load path
  assign line_o = line_q[way_i];
  assign word_o = line_o[wsel];

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // ========================================================================
  // widths that carry a meaning
  // ========================================================================

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;

  // default geometry, overridden only from the top level
  localparam int DEF_IDX_W      = 4;
  localparam int DEF_LINE_WORDS = 4;

  // ========================================================================
  // request encodings
  // ========================================================================

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_e;

  // unsigned variants share the low bits of their signed sizes
  typedef enum logic [2:0] {
    SZ_B  = 3'd0,
    SZ_H  = 3'd1,
    SZ_W  = 3'd2,
    SZ_BU = 3'd4,
    SZ_HU = 3'd5
  } size_e;

  typedef struct packed {
    op_e   op;
    size_e size;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } meta_t;

  // one write-back beat, addr is the line base for every beat
  typedef struct packed {
    addr_t addr;
    word_t data;
    logic  last;
  } mem_wr_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WB,
    ST_RD_REQ,
    ST_REFILL,
    ST_REPLAY
  } dc_state_e;

endpackage

`default_nettype wire

//--- logic/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store #(
  parameter int IDX_W      = 4,
  parameter int LINE_WORDS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rd_en_i,
  input  dcache_pkg::addr_t rd_addr_i,
  input  dcache_pkg::addr_t cmp_addr_i,
  output logic              hit_o,
  output logic              hit_way_o,
  output logic              victim_way_o,
  output dcache_pkg::meta_t victim_meta_o,
  output dcache_pkg::addr_t victim_addr_o,
  input  logic              fill_i,
  input  logic              fill_way_i,
  input  logic              dirty_set_i
);
  import dcache_pkg::*;

  localparam int OFS_W = 2 + $clog2(LINE_WORDS);
  localparam int TAG_W = 32 - OFS_W - IDX_W;
  localparam int SETS  = 1 << IDX_W;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;

  tag_t            tag_mem  [2][SETS];
  meta_t           meta_mem [2][SETS];
  logic [SETS-1:0] plru_mem;

  // registered read port
  tag_t  tag_q  [2];
  meta_t meta_q [2];
  logic  plru_q;
  logic  rd_vld_q;

  idx_t       rd_idx;
  idx_t       cmp_idx;
  tag_t       cmp_tag;
  logic [1:0] way_hit;

  assign rd_idx  = rd_addr_i[OFS_W +: IDX_W];
  assign cmp_idx = cmp_addr_i[OFS_W +: IDX_W];
  assign cmp_tag = cmp_addr_i[31 -: TAG_W];

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      tag_q[0] <= tag_mem[0][rd_idx];
      tag_q[1] <= tag_mem[1][rd_idx];
    end
    if (fill_i) begin
      tag_mem[fill_way_i][cmp_idx] <= cmp_tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        meta_mem[0][s] <= '0;
        meta_mem[1][s] <= '0;
      end
      plru_mem <= '0;
      meta_q[0] <= '0;
      meta_q[1] <= '0;
      plru_q    <= 1'b0;
      rd_vld_q  <= 1'b0;
    end else begin
      rd_vld_q <= rd_en_i;
      if (rd_en_i) begin
        meta_q[0] <= meta_mem[0][rd_idx];
        meta_q[1] <= meta_mem[1][rd_idx];
        plru_q    <= plru_mem[rd_idx];
      end
      // refilled line comes in clean
      if (fill_i) begin
        meta_mem[fill_way_i][cmp_idx] <= '{valid: 1'b1, dirty: 1'b0};
      end
      if (dirty_set_i) begin
        meta_mem[hit_way_o][cmp_idx].dirty <= 1'b1;
      end
      // plru names the next victim, so point it at the other way
      if (rd_vld_q && hit_o) begin
        plru_mem[cmp_idx] <= ~hit_way_o;
      end
    end
  end

  // ========================================================================
  // hit detection and victim choice
  // ========================================================================

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = meta_q[w].valid && (tag_q[w] == cmp_tag);
    end
    hit_o     = |way_hit;
    hit_way_o = way_hit[1];

    // an empty way wins over the plru choice
    if (!meta_q[0].valid) begin
      victim_way_o = 1'b0;
    end else if (!meta_q[1].valid) begin
      victim_way_o = 1'b1;
    end else begin
      victim_way_o = plru_q;
    end
    victim_meta_o = meta_q[victim_way_o];
    victim_addr_o = {tag_q[victim_way_o], cmp_idx, {OFS_W{1'b0}}};
  end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid_i,
  input  dcache_pkg::cpu_req_t req_i,
  output logic                 req_ready_o,
  output logic                 rsp_valid_o,
  output dcache_pkg::word_t    rsp_rdata_o,
  output logic                 mem_wr_valid_o,
  output dcache_pkg::mem_wr_t  mem_wr_o,
  input  logic                 mem_wr_ready_i,
  output logic                 mem_rd_req_valid_o,
  output dcache_pkg::addr_t    mem_rd_addr_o,
  input  logic                 mem_rd_req_ready_i,
  input  logic                 mem_rd_valid_i,
  input  dcache_pkg::word_t    mem_rd_data_i,
  input  logic                 mem_rd_last_i
);
  import dcache_pkg::*;

  localparam int IDX_W      = DEF_IDX_W;
  localparam int LINE_WORDS = DEF_LINE_WORDS;

  // tag store
  logic  rd_en;
  addr_t rd_addr;
  addr_t cmp_addr;
  logic  hit;
  logic  hit_way;
  logic  victim_way;
  meta_t victim_meta;
  addr_t victim_addr;
  logic  fill;
  logic  fill_way;
  logic  dirty_set;

  // data store
  logic                   line_we;
  logic                   word_we;
  logic                   way;
  word_t [LINE_WORDS-1:0] refill_line;
  word_t [LINE_WORDS-1:0] rd_line;
  word_t                  rd_word;

  // word align
  size_e      size;
  logic [1:0] ofs;
  word_t      wdata;
  word_t      wlane;
  word_t      rdata;
  be_t        be;

  dcache_ctrl #(
    .IDX_W      (IDX_W),
    .LINE_WORDS (LINE_WORDS)
  ) u_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_valid_i        (req_valid_i),
    .req_i              (req_i),
    .req_ready_o        (req_ready_o),
    .rsp_valid_o        (rsp_valid_o),
    .rsp_rdata_o        (rsp_rdata_o),
    .mem_wr_valid_o     (mem_wr_valid_o),
    .mem_wr_o           (mem_wr_o),
    .mem_wr_ready_i     (mem_wr_ready_i),
    .mem_rd_req_valid_o (mem_rd_req_valid_o),
    .mem_rd_addr_o      (mem_rd_addr_o),
    .mem_rd_req_ready_i (mem_rd_req_ready_i),
    .mem_rd_valid_i     (mem_rd_valid_i),
    .mem_rd_data_i      (mem_rd_data_i),
    .mem_rd_last_i      (mem_rd_last_i),
    .rd_en_o            (rd_en),
    .rd_addr_o          (rd_addr),
    .cmp_addr_o         (cmp_addr),
    .hit_i              (hit),
    .hit_way_i          (hit_way),
    .victim_way_i       (victim_way),
    .victim_meta_i      (victim_meta),
    .victim_addr_i      (victim_addr),
    .fill_o             (fill),
    .fill_way_o         (fill_way),
    .dirty_set_o        (dirty_set),
    .line_we_o          (line_we),
    .refill_line_o      (refill_line),
    .word_we_o          (word_we),
    .way_o              (way),
    .line_i             (rd_line),
    .size_o             (size),
    .ofs_o              (ofs),
    .wdata_o            (wdata),
    .rdata_i            (rdata)
  );

  dcache_tag_store #(
    .IDX_W      (IDX_W),
    .LINE_WORDS (LINE_WORDS)
  ) u_tag (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_en_i       (rd_en),
    .rd_addr_i     (rd_addr),
    .cmp_addr_i    (cmp_addr),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .victim_way_o  (victim_way),
    .victim_meta_o (victim_meta),
    .victim_addr_o (victim_addr),
    .fill_i        (fill),
    .fill_way_i    (fill_way),
    .dirty_set_i   (dirty_set)
  );

  // word address is the latched request address
  dcache_data_store #(
    .IDX_W      (IDX_W),
    .LINE_WORDS (LINE_WORDS)
  ) u_data (
    .clk         (clk),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .way_i       (way),
    .line_we_i   (line_we),
    .line_i      (refill_line),
    .word_we_i   (word_we),
    .word_addr_i (cmp_addr),
    .word_i      (wlane),
    .be_i        (be),
    .word_o      (rd_word),
    .line_o      (rd_line)
  );

  dcache_word_align u_align (
    .size_i  (size),
    .ofs_i   (ofs),
    .word_i  (rd_word),
    .rdata_o (rdata),
    .wdata_i (wdata),
    .wlane_o (wlane),
    .be_o    (be)
  );

endmodule

`default_nettype wire

//--- logic/dcache_word_align.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_word_align (
  input  dcache_pkg::size_e size_i,
  input  logic [1:0]        ofs_i,
  input  dcache_pkg::word_t word_i,
  output dcache_pkg::word_t rdata_o,
  input  dcache_pkg::word_t wdata_i,
  output dcache_pkg::word_t wlane_o,
  output dcache_pkg::be_t   be_o
);
  import dcache_pkg::*;

  word_t shifted;

  // load path, addressed lane moved down to bit 0 then extended
  always_comb begin
    shifted = word_i >> {ofs_i, 3'b000};
    case (size_i)
      SZ_B:    rdata_o = {{24{shifted[7]}}, shifted[7:0]};
      SZ_BU:   rdata_o = {24'h0, shifted[7:0]};
      SZ_H:    rdata_o = {{16{shifted[15]}}, shifted[15:0]};
      SZ_HU:   rdata_o = {16'h0, shifted[15:0]};
      default: rdata_o = word_i;
    endcase
  end

  // store path, data copied to every lane and byte enables pick the right one
  always_comb begin
    case (size_i)
      SZ_B, SZ_BU: begin
        wlane_o = {4{wdata_i[7:0]}};
        be_o    = be_t'(4'b0001 << ofs_i);
      end
      SZ_H, SZ_HU: begin
        wlane_o = {2{wdata_i[15:0]}};
        be_o    = be_t'(4'b0011 << ofs_i);
      end
      default: begin
        wlane_o = wdata_i;
        be_o    = 4'b1111;
      end
    endcase
  end

endmodule

`default_nettype wire
